//--- all.f
rtl/drive_pkg.sv
rtl/apb_regs.sv
rtl/period_timer.sv
rtl/drive_sequencer.sv
rtl/intensity_encoder.sv
rtl/pwm_bank.sv
rtl/drive_top.sv
verification/drive_tb.sv

//--- rtl/apb_regs.sv
`timescale 1ns/1ps
module apb_regs #(
  parameter int DEPTH = 8
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic [drive_pkg::addr_w-1:0]             paddr,
  input  logic [31:0]                              pwdata,
  output logic [31:0]                              prdata,
  output logic                                     pready,
  output logic                                     pslverr,
  output logic                                     enable,
  output logic [drive_pkg::cnt_w-1:0]              mod_value,
  output logic                                     tbl_we,
  output logic [drive_pkg::clog2_min1(DEPTH)-1:0]  tbl_idx,
  output logic [15:0]                              tbl_data
);

  import drive_pkg::*;

  localparam int chan_w = clog2_min1(DEPTH);

  logic              access;
  logic              wr_acc;
  logic              hit_ctrl;
  logic              hit_mod;
  logic              hit_tbl;
  logic [addr_w-1:0] tbl_off;
  logic [addr_w-3:0] tbl_word;

  assign access = psel && penable;
  assign wr_acc = access && pwrite;

  // address decode.
  assign hit_ctrl = (paddr == reg_ctrl);
  assign hit_mod  = (paddr == reg_mod);
  assign tbl_off  = paddr - reg_table_base;
  assign tbl_word = tbl_off[addr_w-1:2];
  assign hit_tbl  = (paddr >= reg_table_base) && (tbl_off[1:0] == 2'b00) &&
                    (int'(tbl_word) < DEPTH);

  // no wait states, every access completes in its access phase.
  assign pready  = 1'b1;
  assign pslverr = access && !(hit_ctrl || hit_mod || hit_tbl);

  // table is write only, so its window reads as zero.
  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata[0] = enable;
    end else if (hit_mod) begin
      prdata[cnt_w-1:0] = mod_value;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable    <= 1'b0;
      mod_value <= '0;
    end else if (wr_acc) begin
      if (hit_ctrl) begin
        enable <= pwdata[0];
      end
      if (hit_mod) begin
        mod_value <= pwdata[cnt_w-1:0];
      end
    end
  end

  // table writes leave as a single-cycle strobe.
  assign tbl_we   = wr_acc && hit_tbl;
  assign tbl_idx  = tbl_word[chan_w-1:0];
  assign tbl_data = pwdata[15:0];

endmodule

//--- rtl/drive_pkg.sv
package drive_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath widths and timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // counter, intensity, phase and pulse width share one width.
  localparam int cnt_w = 8;
  // one carrier period in clock cycles.
  localparam int period_len = 256;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // apb register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int addr_w = 12;
  // bit 0 is the output enable.
  localparam logic [addr_w-1:0] reg_ctrl = 12'h000;
  // bits 7:0 hold the modulation value.
  localparam logic [addr_w-1:0] reg_mod = 12'h004;
  // channel i at base + 4*i, phase in 15:8, intensity in 7:0.
  localparam logic [addr_w-1:0] reg_table_base = 12'h100;

  // channel index width, at least one bit even for a single channel.
  function automatic int clog2_min1(input int n);
    int w;
    w = $clog2(n);
    return (w < 1) ? 1 : w;
  endfunction

endpackage

//--- rtl/drive_sequencer.sv
`timescale 1ns/1ps
module drive_sequencer #(
  parameter int DEPTH = 8
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     update,
  input  logic                                     tbl_we,
  input  logic [drive_pkg::clog2_min1(DEPTH)-1:0]  tbl_idx,
  input  logic [15:0]                              tbl_data,
  output logic                                     seq_valid,
  output logic [drive_pkg::clog2_min1(DEPTH)-1:0]  seq_idx,
  output logic [drive_pkg::cnt_w-1:0]              seq_int,
  output logic [drive_pkg::cnt_w-1:0]              seq_phase
);

  import drive_pkg::*;

  localparam int chan_w = clog2_min1(DEPTH);
  localparam logic [chan_w-1:0] last_idx = chan_w'(DEPTH - 1);

  // one word per channel, phase high and intensity low.
  logic [15:0] tbl_mem [DEPTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        tbl_mem[i] <= '0;
      end
    end else if (tbl_we) begin
      tbl_mem[tbl_idx] <= tbl_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stream walker
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // entry 0 is presented the cycle after update, then one per cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seq_valid <= 1'b0;
      seq_idx   <= '0;
    end else if (update) begin
      seq_valid <= 1'b1;
      seq_idx   <= '0;
    end else if (seq_valid && (seq_idx != last_idx)) begin
      seq_idx <= seq_idx + 1'b1;
    end else begin
      seq_valid <= 1'b0;
    end
  end

  assign seq_int   = tbl_mem[seq_idx][cnt_w-1:0];
  assign seq_phase = tbl_mem[seq_idx][15:cnt_w];

endmodule

//--- rtl/drive_top.sv
`timescale 1ns/1ps
module drive_top #(
  parameter int DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [drive_pkg::addr_w-1:0] paddr,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic [DEPTH-1:0]            pwm_out,
  output logic [drive_pkg::cnt_w-1:0] cycle_cnt
);

  import drive_pkg::*;

  localparam int chan_w = clog2_min1(DEPTH);

  logic              enable;
  logic [cnt_w-1:0]  mod_value;
  logic              tbl_we;
  logic [chan_w-1:0] tbl_idx;
  logic [15:0]       tbl_data;

  logic              update;

  logic              seq_valid;
  logic [chan_w-1:0] seq_idx;
  logic [cnt_w-1:0]  seq_int;
  logic [cnt_w-1:0]  seq_phase;

  logic              enc_valid;
  logic [chan_w-1:0] enc_idx;
  logic [cnt_w-1:0]  enc_width;
  logic [cnt_w-1:0]  enc_phase;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  apb_regs #(
    .DEPTH(DEPTH)
  ) apb_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .enable   (enable),
    .mod_value(mod_value),
    .tbl_we   (tbl_we),
    .tbl_idx  (tbl_idx),
    .tbl_data (tbl_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-period processing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  period_timer period_timer (
    .clk   (clk),
    .arst_n(arst_n),
    .cnt   (cycle_cnt),
    .update(update)
  );

  drive_sequencer #(
    .DEPTH(DEPTH)
  ) drive_sequencer (
    .clk      (clk),
    .arst_n   (arst_n),
    .update   (update),
    .tbl_we   (tbl_we),
    .tbl_idx  (tbl_idx),
    .tbl_data (tbl_data),
    .seq_valid(seq_valid),
    .seq_idx  (seq_idx),
    .seq_int  (seq_int),
    .seq_phase(seq_phase)
  );

  intensity_encoder #(
    .IDX_W(chan_w)
  ) intensity_encoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .mod_value(mod_value),
    .seq_valid(seq_valid),
    .seq_idx  (seq_idx),
    .seq_int  (seq_int),
    .seq_phase(seq_phase),
    .enc_valid(enc_valid),
    .enc_idx  (enc_idx),
    .enc_width(enc_width),
    .enc_phase(enc_phase)
  );

  // output side.
  pwm_bank #(
    .DEPTH(DEPTH)
  ) pwm_bank (
    .clk      (clk),
    .arst_n   (arst_n),
    .enable   (enable),
    .cnt      (cycle_cnt),
    .update   (update),
    .enc_valid(enc_valid),
    .enc_idx  (enc_idx),
    .enc_width(enc_width),
    .enc_phase(enc_phase),
    .pwm_out  (pwm_out)
  );

endmodule

//--- rtl/intensity_encoder.sv
`timescale 1ns/1ps
module intensity_encoder #(
  parameter int IDX_W = 3
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [drive_pkg::cnt_w-1:0] mod_value,
  input  logic                        seq_valid,
  input  logic [IDX_W-1:0]            seq_idx,
  input  logic [drive_pkg::cnt_w-1:0] seq_int,
  input  logic [drive_pkg::cnt_w-1:0] seq_phase,
  output logic                        enc_valid,
  output logic [IDX_W-1:0]            enc_idx,
  output logic [drive_pkg::cnt_w-1:0] enc_width,
  output logic [drive_pkg::cnt_w-1:0] enc_phase
);

  import drive_pkg::*;

  logic [2*cnt_w-1:0] product;
  logic               s1_valid;
  logic [IDX_W-1:0]   s1_idx;
  logic [cnt_w-1:0]   s1_scaled;
  logic [cnt_w-1:0]   s1_phase;

  // intensity * mod / 256 keeps the upper byte of the product.
  assign product = seq_int * mod_value;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      enc_valid <= 1'b0;
    end else begin
      s1_valid  <= seq_valid;
      enc_valid <= s1_valid;
    end
  end

  // stage 1 scales and stage 2 halves into a pulse width.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_scaled <= '0;
      s1_idx    <= '0;
      s1_phase  <= '0;
      enc_width <= '0;
      enc_idx   <= '0;
      enc_phase <= '0;
    end else begin
      s1_scaled <= product[2*cnt_w-1:cnt_w];
      s1_idx    <= seq_idx;
      s1_phase  <= seq_phase;
      enc_width <= s1_scaled >> 1;
      enc_idx   <= s1_idx;
      enc_phase <= s1_phase;
    end
  end

endmodule

//--- rtl/period_timer.sv
`timescale 1ns/1ps
module period_timer (
  input  logic                        clk,
  input  logic                        arst_n,
  output logic [drive_pkg::cnt_w-1:0] cnt,
  output logic                        update
);

  import drive_pkg::*;

  // count value one cycle before the last of the period.
  localparam logic [cnt_w-1:0] pre_last = cnt_w'(period_len - 2);

  // free-running wrap counter.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // registered so update lines up with cnt == 255.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      update <= 1'b0;
    end else begin
      update <= (cnt == pre_last);
    end
  end

endmodule

//--- rtl/pwm_bank.sv
`timescale 1ns/1ps
module pwm_bank #(
  parameter int DEPTH = 8
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     enable,
  input  logic [drive_pkg::cnt_w-1:0]              cnt,
  input  logic                                     update,
  input  logic                                     enc_valid,
  input  logic [drive_pkg::clog2_min1(DEPTH)-1:0]  enc_idx,
  input  logic [drive_pkg::cnt_w-1:0]              enc_width,
  input  logic [drive_pkg::cnt_w-1:0]              enc_phase,
  output logic [DEPTH-1:0]                         pwm_out
);

  import drive_pkg::*;

  logic [cnt_w-1:0] shadow_width [DEPTH];
  logic [cnt_w-1:0] shadow_phase [DEPTH];
  logic [cnt_w-1:0] active_width [DEPTH];
  logic [cnt_w-1:0] active_phase [DEPTH];
  logic [cnt_w-1:0] offs         [DEPTH];

  // shadow side fills from the encoder stream.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        shadow_width[i] <= '0;
        shadow_phase[i] <= '0;
      end
    end else if (enc_valid) begin
      shadow_width[enc_idx] <= enc_width;
      shadow_phase[enc_idx] <= enc_phase;
    end
  end

  // active side only changes at a period boundary.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        active_width[i] <= '0;
        active_phase[i] <= '0;
      end
    end else if (update) begin
      for (int i = 0; i < DEPTH; i++) begin
        active_width[i] <= shadow_width[i];
        active_phase[i] <= shadow_phase[i];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // phase-shifted compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // wraps modulo 256 by width.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      offs[i] = cnt - active_phase[i];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pwm_out <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        pwm_out[i] <= enable && (offs[i] < active_width[i]);
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run drive_tb with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module drive_tb -f all.f -o drive_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/drive_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi
echo "pass message missing from sim.log"
exit 1

//--- verification/drive_stim.txt
# W addr data | R addr exp_prdata exp_pslverr | P channel exp_width exp_phase
# all fields hex; table word is phase:intensity, width = (intensity * mod / 256) / 2
W 004 00000080
W 100 00000040
W 104 000010FF
W 108 0000F0C8
W 11C 00002080
W 000 00000001
R 000 00000001 0
R 004 00000080 0
R 104 00000000 0
R 008 00000000 1
R 120 00000000 1
P 0 10 00
P 1 3F 10
P 2 32 F0
P 7 20 20
W 004 000000FF
P 0 1F 00
P 1 7F 10
P 2 63 F0
P 7 3F 20
W 000 00000000
P 0 00 00
P 1 00 10
P 2 00 F0
P 7 00 20

//--- verification/drive_tb.sv
`timescale 1ns/1ps
module drive_tb;

  import drive_pkg::*;

  localparam int DEPTH = 8;
  localparam int max_wait = 300;

  logic              clk;
  logic              arst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic [DEPTH-1:0]  pwm_out;
  logic [cnt_w-1:0]  cycle_cnt;

  integer            seed;
  logic              stale;
  logic [DEPTH-1:0]  smp_out [period_len];
  logic [cnt_w-1:0]  smp_cnt [period_len];

  drive_top #(.DEPTH(DEPTH)) dut_i (.*);

  always #50 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks and waits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // polls on the falling edge, where outputs are settled.
  task automatic wait_for_count(input logic [cnt_w-1:0] value);
    int n;
    n = 0;
    @(negedge clk);
    while (cycle_cnt != value) begin
      if (n == max_wait) abort($sformatf("cycle_cnt did not reach %0d in time", value));
      @(negedge clk);
      n++;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [addr_w-1:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata,
                            output logic err);
    int idle;
    int tries;
    idle = $random(seed) & 3;
    repeat (idle) @(negedge clk);
    psel   = 1'b1;
    pwrite = wr;
    paddr  = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    tries   = 0;
    #1;
    while (!pready) begin
      if (tries == 16) abort("APB access did not complete within 16 cycles");
      @(negedge clk);
      #1;
      tries++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // window is cycle_cnt 1 through 0, the span driven by one active set.
  task automatic measure_period();
    wait_for_count('0);
    wait_for_count('0);
    for (int s = 0; s < period_len; s++) begin
      @(negedge clk);
      smp_out[s] = pwm_out;
      smp_cnt[s] = cycle_cnt;
      check("cycle_cnt", 32'(cycle_cnt), (s + 1) % period_len);
    end
  endtask

  task automatic check_channel(input int ch, input logic [cnt_w-1:0] exp_w,
                               input logic [cnt_w-1:0] exp_ph);
    int               high;
    int               rises;
    int               prev;
    logic [cnt_w-1:0] rise_at;
    logic [cnt_w-1:0] exp_rise;
    if (ch >= DEPTH) abort($sformatf("stim file names channel %0d, which is not built", ch));
    high     = 0;
    rises    = 0;
    rise_at  = '0;
    exp_rise = exp_ph + 1'b1;
    for (int s = 0; s < period_len; s++) begin
      prev = (s + period_len - 1) % period_len;
      if (smp_out[s][ch]) high++;
      if (smp_out[s][ch] && !smp_out[prev][ch]) begin
        rises++;
        rise_at = smp_cnt[s];
      end
    end
    check($sformatf("pwm_out[%0d] high cycles", ch), high, 32'(exp_w));
    // a zero-width channel never rises.
    if (exp_w != 0) begin
      check($sformatf("pwm_out[%0d] rising edges", ch), rises, 1);
      check($sformatf("pwm_out[%0d] rise cycle_cnt", ch), 32'(rise_at), 32'(exp_rise));
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          c;
    logic [63:0] tok;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] rdata;
    logic        err;
    seed    = 79;
    clk     = 1'b0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    stale   = 1'b0;
    repeat (16) @(negedge clk);
    check("pwm_out", 32'(pwm_out), 0);
    arst_n = 1'b1;

    fd = $fopen("verification/drive_stim.txt", "r");
    if (fd == 0) abort("could not open verification/drive_stim.txt");
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) c = $fgetc(fd);
      end else if (tok == "W") begin
        n = $fscanf(fd, "%h %h", f1, f2);
        if (n != 2) abort("stim file has a W line with missing fields");
        apb_access(1'b1, f1[addr_w-1:0], f2, rdata, err);
        check("pslverr", 32'(err), 0);
        stale = 1'b1;
      end else if (tok == "R") begin
        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (n != 3) abort("stim file has an R line with missing fields");
        apb_access(1'b0, f1[addr_w-1:0], '0, rdata, err);
        check("prdata", rdata, f2);
        check("pslverr", 32'(err), f3);
      end else if (tok == "P") begin
        n = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (n != 3) abort("stim file has a P line with missing fields");
        // the first output check after any write waits for it to take effect.
        if (stale) measure_period();
        stale = 1'b0;
        check_channel(f1, f2[cnt_w-1:0], f3[cnt_w-1:0]);
      end else begin
        abort($sformatf("stim file holds an unknown line kind %0s", tok));
      end
    end
    $fclose(fd);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
